//--- hw/i2c_bus_pkg.sv
// I2C bus types shared by the touch controller master: pad enables, line samples, FSM states
package i2c_bus_pkg;

    // transaction-level FSM states of the sequencer
    typedef enum logic [2:0] {
        st_idle       = 3'd0,
        st_start      = 3'd1,
        st_addr_byte  = 3'd2,
        st_write_byte = 3'd3,
        st_read_hi    = 3'd4,
        st_read_lo    = 3'd5,
        st_stop       = 3'd6
    } ctrl_state_t;

    // quarter-bit steps of one SCL period
    typedef enum logic [1:0] {
        ph_low_setup   = 2'd0,   // scl low, sda may change
        ph_rise        = 2'd1,   // scl released
        ph_high_sample = 2'd2,   // scl high, sda sampled
        ph_fall        = 2'd3    // scl pulled low again
    } bit_phase_t;

    typedef struct packed {
        logic scl_oe;   // 1 pulls scl low
        logic sda_oe;   // 1 pulls sda low
    } i2c_pads_t;

    typedef struct packed {
        logic scl_in;   // resolved line levels
        logic sda_in;
    } i2c_sample_t;

    localparam logic [3:0] ACK_BIT_IDX = 4'd8;   // ninth bit of every byte

endpackage

//--- hw/touch_regs_pkg.sv
// Host side definitions of the touch I2C master: Wishbone structs, command and register map
package touch_regs_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;   // word address
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;   // valid with ack
    } wb_rsp_t;

    typedef struct packed {
        logic       rw;         // 1 = read two bytes
        logic [7:0] cmd_byte;   // sent on writes only
    } touch_cmd_t;

    localparam logic [3:0] REG_CTRL   = 4'd0;
    localparam logic [3:0] REG_STATUS = 4'd1;
    localparam logic [3:0] REG_RDATA  = 4'd2;

    // bit positions in REG_STATUS
    localparam int STATUS_BUSY = 0;
    localparam int STATUS_NACK = 1;
    localparam int STATUS_DONE = 2;

endpackage

//--- hw/scl_tick_gen.sv
// Quarter-bit timer for the I2C master, one tick every CLK_DIV clocks while enabled
`timescale 1ns/1ps

module scl_tick_gen #(
    parameter int CLK_DIV = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic tick_en,
    output logic tick
);

    localparam int               CNT_W  = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLK_DIV - 1);

    logic [CNT_W-1:0] cnt;   // clocks left in this quarter bit

    assign tick = tick_en && (cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= RELOAD;
        end else if (!tick_en || cnt == '0) begin
            cnt <= RELOAD;   // parked so the first tick is a full period away
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    // a tick only comes out of an enable that was already high the clock before
    assert property (@(posedge clk) disable iff (!rst_n)
        tick |-> (CLK_DIV == 1 || $past(tick_en)));

endmodule

//--- hw/i2c_byte_shifter.sv
// Byte shifter of the I2C master, serializes transmit bytes and collects a 16-bit read result
`timescale 1ns/1ps

module i2c_byte_shifter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load,
    input  logic [7:0]  tx_byte,
    input  logic        shift_out,
    input  logic        shift_in,
    input  logic        rx_bit,
    output logic        tx_bit,
    output logic [15:0] rx_word
);

    logic [7:0]  tx_reg;
    logic [15:0] rx_reg;

    assign tx_bit  = tx_reg[7];   // msb first on the wire
    assign rx_word = rx_reg;

    // transmit side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_reg <= '0;
        end else if (load) begin
            tx_reg <= tx_byte;
        end else if (shift_out) begin
            tx_reg <= {tx_reg[6:0], 1'b1};   // ones fill in, a spent byte leaves sda released
        end
    end

    // receive side, first byte ends up in the upper half
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_reg <= '0;
        end else if (load) begin
            rx_reg <= '0;   // new transaction
        end else if (shift_in) begin
            rx_reg <= {rx_reg[14:0], rx_bit};
        end
    end

endmodule

//--- hw/i2c_sequencer.sv
// I2C master FSM, runs one write or two-byte read transaction on open-drain SCL and SDA enables
`timescale 1ns/1ps

module i2c_sequencer #(
    parameter logic [6:0] DEV_ADDR = 7'h48
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  touch_regs_pkg::touch_cmd_t cmd,
    input  logic                       tick,
    input  i2c_bus_pkg::i2c_sample_t   sample,
    input  logic                       tx_bit,
    output i2c_bus_pkg::i2c_pads_t     pads,
    output logic                       tick_en,
    output logic                       load,
    output logic [7:0]                 tx_byte,
    output logic                       shift_out,
    output logic                       shift_in,
    output logic                       busy,
    output logic                       done,
    output logic                       nack
);
    import i2c_bus_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;   // successor after the current byte
    bit_phase_t  phase;
    logic [3:0]  bit_cnt;      // 0..7 data, 8 = acknowledge
    logic        rw_r;
    logic [7:0]  cmd_byte_r;

    logic ack_bit;
    logic tx_state;            // master drives the data bits
    logic rx_state;            // target drives the data bits
    logic byte_end;

    assign ack_bit  = (bit_cnt == ACK_BIT_IDX);
    assign tx_state = (state == st_addr_byte) || (state == st_write_byte);
    assign rx_state = (state == st_read_hi) || (state == st_read_lo);
    assign byte_end = tick && (phase == ph_fall) && ack_bit;

    assign shift_out = tick && tx_state && (phase == ph_high_sample) && !ack_bit;
    assign shift_in  = tick && rx_state && (phase == ph_high_sample) && !ack_bit;

    // address goes in on the start request, the command byte after a good address ack
    always_comb begin
        load    = 1'b0;
        tx_byte = {DEV_ADDR, cmd.rw};
        if (state == st_idle && start) begin
            load = 1'b1;
        end else if (byte_end && state == st_addr_byte && !rw_r && !nack) begin
            load    = 1'b1;
            tx_byte = cmd_byte_r;
        end
    end

    always_comb begin
        case (state)
            st_addr_byte: next_state = nack ? st_stop : (rw_r ? st_read_hi : st_write_byte);
            st_read_hi:   next_state = st_read_lo;
            default:      next_state = st_stop;   // write byte and low read byte end here
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            phase      <= ph_low_setup;
            bit_cnt    <= '0;
            rw_r       <= 1'b0;
            cmd_byte_r <= '0;
            pads       <= '0;
            tick_en    <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
            nack       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        rw_r       <= cmd.rw;
                        cmd_byte_r <= cmd.cmd_byte;
                        busy       <= 1'b1;
                        tick_en    <= 1'b1;
                        nack       <= 1'b0;
                        phase      <= ph_low_setup;
                        state      <= st_start;
                    end
                end
                // two ticks, the first two phase codes serve as steps
                st_start: begin
                    if (tick) begin
                        if (phase == ph_low_setup) begin
                            pads.sda_oe <= 1'b1;   // sda falls under a high scl
                            phase       <= ph_rise;
                        end else begin
                            pads.scl_oe <= 1'b1;
                            phase       <= ph_low_setup;
                            bit_cnt     <= '0;
                            state       <= st_addr_byte;
                        end
                    end
                end
                st_addr_byte, st_write_byte, st_read_hi, st_read_lo: begin
                    if (tick) begin
                        case (phase)
                            ph_low_setup: begin
                                // ack bit: master acks the high byte, nacks the low one
                                pads.sda_oe <= ack_bit ? (state == st_read_hi)
                                                       : (tx_state && !tx_bit);
                                phase       <= ph_rise;
                            end
                            ph_rise: begin
                                pads.scl_oe <= 1'b0;
                                phase       <= ph_high_sample;
                            end
                            ph_high_sample: begin
                                if (ack_bit && tx_state && sample.sda_in) begin
                                    nack <= 1'b1;   // target left sda high
                                end
                                phase <= ph_fall;
                            end
                            ph_fall: begin
                                pads.scl_oe <= 1'b1;
                                phase       <= ph_low_setup;
                                bit_cnt     <= bit_cnt + 1'b1;
                                if (ack_bit) begin
                                    bit_cnt <= '0;
                                    state   <= next_state;
                                end
                            end
                        endcase
                    end
                end
                st_stop: begin
                    if (phase == ph_low_setup) begin
                        pads.sda_oe <= 1'b1;   // pull sda low one clock after scl fell
                        if (tick) begin
                            pads.scl_oe <= 1'b0;
                            phase       <= ph_rise;
                        end
                    end else if (tick) begin
                        pads.sda_oe <= 1'b0;   // sda rises under a high scl
                        tick_en     <= 1'b0;
                        busy        <= 1'b0;
                        done        <= 1'b1;
                        phase       <= ph_low_setup;
                        state       <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // data on sda only moves while scl is held low, start and stop excepted
    assert property (@(posedge clk) disable iff (!rst_n)
        ($changed(pads.sda_oe) && !($past(state) inside {st_start, st_stop}))
        |-> (pads.scl_oe && $past(pads.scl_oe)));

    // the register block must hold a new start until this transaction is over
    assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

    // no clock stretching is supported, a released scl reads high at the sample point
    assert property (@(posedge clk) disable iff (!rst_n)
        (tick && phase == ph_high_sample && (tx_state || rx_state)) |-> sample.scl_in);

endmodule

//--- hw/touch_wb_regs.sv
// Wishbone classic slave with the command, status and read data registers of the touch master
`timescale 1ns/1ps

module touch_wb_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  touch_regs_pkg::wb_req_t    wb_req,
    input  logic                       busy,
    input  logic                       done,
    input  logic                       nack,
    input  logic [15:0]                rx_word,
    output touch_regs_pkg::wb_rsp_t    wb_rsp,
    output logic                       start,
    output touch_regs_pkg::touch_cmd_t cmd
);
    import touch_regs_pkg::*;

    logic        access;       // new cycle seen this clock
    logic        ctrl_write;
    logic        accept_start;
    logic        done_r;       // sticky until the next start
    logic        nack_r;
    logic [15:0] rdata_r;
    logic [31:0] rd_mux;

    assign access       = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign ctrl_write   = access && wb_req.we && (wb_req.adr == REG_CTRL);
    assign accept_start = ctrl_write && !busy && !start;   // writes while busy are dropped

    always_comb begin
        rd_mux = '0;
        case (wb_req.adr)
            REG_CTRL:   rd_mux[8:0] = cmd;
            REG_STATUS: begin
                rd_mux[STATUS_BUSY] = busy || start;   // covers the clock before busy rises
                rd_mux[STATUS_NACK] = nack_r;
                rd_mux[STATUS_DONE] = done_r;
            end
            REG_RDATA:  rd_mux[15:0] = rdata_r;
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_rsp  <= '0;
            start   <= 1'b0;
            cmd     <= '0;
            done_r  <= 1'b0;
            nack_r  <= 1'b0;
            rdata_r <= '0;
        end else begin
            wb_rsp.ack <= access;   // single clock ack, no wait states
            if (access) begin
                wb_rsp.dat <= rd_mux;
            end
            start <= accept_start;
            if (accept_start) begin
                cmd <= touch_cmd_t'(wb_req.dat[8:0]);
            end
            if (start) begin
                done_r <= 1'b0;
                nack_r <= 1'b0;
            end else if (done) begin
                done_r <= 1'b1;
                nack_r <= nack;
                if (cmd.rw) begin
                    rdata_r <= rx_word;
                end
            end
        end
    end

    // a new start never lands on the clock that reports done
    assert property (@(posedge clk) disable iff (!rst_n) done |-> !start);

endmodule

//--- hw/touch_i2c_top.sv
// Top level of the touch controller I2C master, Wishbone host port and split open-drain pads
`timescale 1ns/1ps

module touch_i2c_top #(
    parameter int         CLK_DIV  = 16,
    parameter logic [6:0] DEV_ADDR = 7'h48
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  touch_regs_pkg::wb_req_t  wb_req,
    input  i2c_bus_pkg::i2c_sample_t i2c_in,
    output touch_regs_pkg::wb_rsp_t  wb_rsp,
    output i2c_bus_pkg::i2c_pads_t   i2c_out
);
    import touch_regs_pkg::*;

    touch_cmd_t  cmd;
    logic        start;
    logic        busy;
    logic        done;
    logic        nack;
    logic        tick_en;
    logic        tick;
    logic        load;
    logic        shift_out;
    logic        shift_in;
    logic        tx_bit;
    logic [7:0]  tx_byte;
    logic [15:0] rx_word;

    touch_wb_regs u_touch_wb_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_req  (wb_req),
        .busy    (busy),
        .done    (done),
        .nack    (nack),
        .rx_word (rx_word),
        .wb_rsp  (wb_rsp),
        .start   (start),
        .cmd     (cmd)
    );

    i2c_sequencer #(
        .DEV_ADDR (DEV_ADDR)
    ) u_i2c_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cmd       (cmd),
        .tick      (tick),
        .sample    (i2c_in),
        .tx_bit    (tx_bit),
        .pads      (i2c_out),
        .tick_en   (tick_en),
        .load      (load),
        .tx_byte   (tx_byte),
        .shift_out (shift_out),
        .shift_in  (shift_in),
        .busy      (busy),
        .done      (done),
        .nack      (nack)
    );

    scl_tick_gen #(
        .CLK_DIV (CLK_DIV)
    ) u_scl_tick_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick_en (tick_en),
        .tick    (tick)
    );

    i2c_byte_shifter u_i2c_byte_shifter (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .tx_byte   (tx_byte),
        .shift_out (shift_out),
        .shift_in  (shift_in),
        .rx_bit    (i2c_in.sda_in),   // read data straight off the resolved line
        .tx_bit    (tx_bit),
        .rx_word   (rx_word)
    );

endmodule

//--- testbench/tb_clk_gen.sv
// Clock and reset source for the touch I2C testbench, 20 ns period and a 5-cycle reset
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;   // released just after an edge
    end

endmodule

//--- testbench/ns2009_model.sv
// Behavioral NS2009-style I2C target for the testbench, acks its address and returns a reading
`timescale 1ns/1ps

module ns2009_model #(
    parameter logic [6:0] DEV_ADDR = 7'h48
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,        // resets the per-transaction observations
    input  logic        scl,
    input  logic        sda,
    input  logic        addr_ack_en,
    input  logic [15:0] reading,
    output logic        sda_oe,       // 1 pulls sda low
    output logic [8:0]  cap,          // {valid, command byte}
    output logic [1:0]  mack,         // master ack after high byte, after low byte
    output logic [7:0]  frames        // {starts, stops}
);

    logic       prev_scl;
    logic       prev_sda;
    logic       active;
    logic       got_rise;   // a full scl high was seen in this bit
    logic       addr_ok;
    logic       is_read;
    logic [3:0] bit_idx;
    logic [1:0] byte_idx;
    logic [7:0] shreg;
    logic [3:0] starts;
    logic [3:0] stops;

    assign frames = {starts, stops};

    // level of data bit j of read byte b, 1 = high byte
    function automatic logic read_bit(input logic [15:0] val, input logic [1:0] b,
                                      input logic [3:0] j);
        int idx;
        idx = (b == 2'd1) ? 15 - int'(j) : 7 - int'(j);
        return val[idx];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_scl <= 1'b1;
            prev_sda <= 1'b1;
            active   <= 1'b0;
            got_rise <= 1'b0;
            addr_ok  <= 1'b0;
            is_read  <= 1'b0;
            bit_idx  <= '0;
            byte_idx <= '0;
            shreg    <= '0;
            sda_oe   <= 1'b0;
            cap      <= '0;
            mack     <= '0;
            starts   <= '0;
            stops    <= '0;
        end else begin
            prev_scl <= scl;
            prev_sda <= sda;
            if (clear) begin
                cap    <= '0;
                mack   <= '0;
                starts <= '0;
                stops  <= '0;
            end
            if (prev_scl && scl && prev_sda && !sda) begin
                active   <= 1'b1;   // start condition
                got_rise <= 1'b0;
                addr_ok  <= 1'b0;
                is_read  <= 1'b0;
                bit_idx  <= '0;
                byte_idx <= '0;
                sda_oe   <= 1'b0;
                starts   <= starts + 4'd1;
            end else if (prev_scl && scl && !prev_sda && sda) begin
                active <= 1'b0;     // stop condition
                sda_oe <= 1'b0;
                stops  <= stops + 4'd1;
            end else if (active && !prev_scl && scl) begin
                got_rise <= 1'b1;
                if (bit_idx < 4'd8) begin
                    shreg <= {shreg[6:0], sda};
                end else if (addr_ok && is_read && byte_idx == 2'd1) begin
                    mack[1] <= !sda;
                end else if (addr_ok && is_read && byte_idx == 2'd2) begin
                    mack[0] <= !sda;
                end
            end else if (active && prev_scl && !scl && got_rise) begin
                got_rise <= 1'b0;
                if (bit_idx == 4'd7) begin
                    bit_idx <= 4'd8;
                    sda_oe  <= 1'b0;   // released for the master ack on reads
                    if (byte_idx == 2'd0) begin
                        is_read <= shreg[0];
                        if (shreg[7:1] == DEV_ADDR && addr_ack_en) begin
                            addr_ok <= 1'b1;
                            sda_oe  <= 1'b1;
                        end
                    end else if (!is_read && byte_idx == 2'd1) begin
                        cap    <= {1'b1, shreg};   // kept even after a refused address
                        sda_oe <= addr_ok;
                    end
                end else if (bit_idx == 4'd8) begin
                    bit_idx  <= '0;
                    byte_idx <= byte_idx + 2'd1;
                    sda_oe   <= 1'b0;
                    if (addr_ok && is_read && byte_idx < 2'd2) begin
                        sda_oe <= !read_bit(reading, byte_idx + 2'd1, 4'd0);
                    end
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                    sda_oe  <= 1'b0;
                    if (addr_ok && is_read && byte_idx != 2'd0) begin
                        sda_oe <= !read_bit(reading, byte_idx, bit_idx + 4'd1);
                    end
                end
            end
        end
    end

endmodule

//--- testbench/tb_checker.sv
// Result checker of the touch I2C testbench, compares expected and observed values per test
`timescale 1ns/1ps

module tb_checker (
    input  logic        clk,
    input  logic        check_stb,    // one clock per finished test
    input  logic        report_stb,
    input  int          test_id,
    input  int          sub_id,
    input  logic [8:0]  exp_cap,
    input  logic [8:0]  obs_cap,
    input  logic [15:0] exp_rdata,
    input  logic [15:0] obs_rdata,
    input  logic [4:0]  exp_status,   // {scl_oe, sda_oe, done, nack, busy}
    input  logic [4:0]  obs_status,
    input  logic [1:0]  exp_mack,
    input  logic [1:0]  obs_mack,
    input  logic [7:0]  exp_frames,
    input  logic [7:0]  obs_frames,
    output int          test_count,
    output int          fail_count
);

    task automatic compare_field(input string name, input logic [15:0] exp_v,
                                 input logic [15:0] obs_v, inout int bad);
        if (exp_v !== obs_v) begin
            $display("MISMATCH test %0d.%0d %s expected %h got %h",
                     test_id, sub_id, name, exp_v, obs_v);
            bad++;
        end
    endtask

    initial begin
        test_count = 0;
        fail_count = 0;
    end

    always @(posedge clk) begin
        int bad;
        bad = 0;
        if (check_stb) begin
            compare_field("command capture", {7'h00, exp_cap}, {7'h00, obs_cap}, bad);
            compare_field("rdata", exp_rdata, obs_rdata, bad);
            compare_field("status and pads", {11'h000, exp_status}, {11'h000, obs_status}, bad);
            compare_field("master ack", {14'h0000, exp_mack}, {14'h0000, obs_mack}, bad);
            compare_field("start and stop count", {8'h00, exp_frames}, {8'h00, obs_frames}, bad);
            test_count++;
            if (bad != 0) begin
                fail_count++;
                $display("test %0d.%0d failed", test_id, sub_id);
            end else begin
                $display("test %0d.%0d passed", test_id, sub_id);
            end
        end
        if (report_stb) begin
            $display("checks run: %0d, failed: %0d", test_count, fail_count);
        end
    end

endmodule

//--- testbench/tb_touch_i2c.sv
// Testbench top of the touch I2C master, drives the Wishbone port against an NS2009 model
`timescale 1ns/1ps

module tb_touch_i2c;
    import touch_regs_pkg::*;
    import i2c_bus_pkg::*;

    localparam int         CLK_DIV     = 16;
    localparam logic [6:0] DEV_ADDR    = 7'h48;
    localparam int         NUM_TESTS   = 25;
    localparam int         WATCHDOG_NS = NUM_TESTS * 112 * CLK_DIV * 20 * 2;
    localparam int         POLL_LIMIT  = 112 * CLK_DIV;

    typedef struct packed {
        logic [8:0]  cap;
        logic [15:0] rdata;
        logic        nack;
    } expect_t;

    logic        clk;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    i2c_sample_t i2c_in;
    i2c_pads_t   i2c_out;
    logic        model_sda_oe;
    logic        model_clear;
    logic        addr_ack_en;
    logic [15:0] reading;
    logic [8:0]  model_cap;
    logic [1:0]  model_mack;
    logic [7:0]  model_frames;

    logic        check_stb;
    logic        report_stb;
    int          test_id;
    int          sub_id;
    logic [8:0]  exp_cap;
    logic [15:0] exp_rdata;
    logic [15:0] obs_rdata;
    logic [4:0]  exp_status;
    logic [4:0]  obs_status;
    logic [1:0]  exp_mack;
    logic [7:0]  exp_frames;
    int          test_count;
    int          fail_count;
    int          proto_errors;
    logic [15:0] last_rdata;   // expected REG_RDATA carried between tests

    // wired-AND of both sides, only the master drives scl
    assign i2c_in.scl_in = !i2c_out.scl_oe;
    assign i2c_in.sda_in = !(i2c_out.sda_oe || model_sda_oe);

    tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(5)) u_tb_clk_gen (.clk(clk), .rst_n(rst_n));

    touch_i2c_top #(
        .CLK_DIV  (CLK_DIV),
        .DEV_ADDR (DEV_ADDR)
    ) u_touch_i2c_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_req  (wb_req),
        .i2c_in  (i2c_in),
        .wb_rsp  (wb_rsp),
        .i2c_out (i2c_out)
    );

    ns2009_model #(.DEV_ADDR(DEV_ADDR)) u_ns2009_model (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (model_clear),
        .scl         (i2c_in.scl_in),
        .sda         (i2c_in.sda_in),
        .addr_ack_en (addr_ack_en),
        .reading     (reading),
        .sda_oe      (model_sda_oe),
        .cap         (model_cap),
        .mack        (model_mack),
        .frames      (model_frames)
    );

    tb_checker u_tb_checker (
        .clk        (clk),
        .check_stb  (check_stb),
        .report_stb (report_stb),
        .test_id    (test_id),
        .sub_id     (sub_id),
        .exp_cap    (exp_cap),
        .obs_cap    (model_cap),
        .exp_rdata  (exp_rdata),
        .obs_rdata  (obs_rdata),
        .exp_status (exp_status),
        .obs_status (obs_status),
        .exp_mack   (exp_mack),
        .obs_mack   (model_mack),
        .exp_frames (exp_frames),
        .obs_frames (model_frames),
        .test_count (test_count),
        .fail_count (fail_count)
    );

    // expected outcome of one transaction from the protocol rules
    function automatic expect_t ref_expect(input logic rw, input logic [7:0] cmd_byte,
                                           input logic [15:0] value, input logic addr_ack,
                                           input logic [15:0] prev_rdata);
        expect_t e;
        e.nack = !addr_ack;
        e.cap  = (!rw && addr_ack) ? {1'b1, cmd_byte} : 9'h000;
        if (rw) begin
            e.rdata = addr_ack ? value : 16'h0000;   // receive register cleared at start
        end else begin
            e.rdata = prev_rdata;
        end
        return e;
    endfunction

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
        int waited;
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        waited     = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_rsp.ack && waited < 8);
        if (!wb_rsp.ack) begin
            $display("ERROR: no Wishbone ack for a write to word %0d", adr);
            proto_errors++;
        end
        wb_req = '0;
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
        int waited;
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        waited     = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_rsp.ack && waited < 8);
        if (!wb_rsp.ack) begin
            $display("ERROR: no Wishbone ack for a read of word %0d", adr);
            proto_errors++;
        end
        dat    = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic wait_idle();
        logic [31:0] s;
        int          polls;
        polls = 0;
        do begin
            wb_read(REG_STATUS, s);
            polls++;
        end while (s[STATUS_BUSY] && polls < POLL_LIMIT);
        if (s[STATUS_BUSY]) begin
            $display("ERROR: transaction still busy after %0d status polls", polls);
            proto_errors++;
        end
    endtask

    // reads back the DUT registers and hands one result to the checker
    task automatic submit(input int tid, input int sid, input logic [8:0] e_cap,
                          input logic [15:0] e_rdata, input logic [4:0] e_status,
                          input logic [1:0] e_mack, input logic [7:0] e_frames);
        logic [31:0] d;
        logic [31:0] s;
        wb_read(REG_RDATA, d);
        wb_read(REG_STATUS, s);
        test_id    = tid;
        sub_id     = sid;
        exp_cap    = e_cap;
        exp_rdata  = e_rdata;
        exp_status = e_status;
        exp_mack   = e_mack;
        exp_frames = e_frames;
        obs_rdata  = d[15:0];
        obs_status = {i2c_out.scl_oe, i2c_out.sda_oe, s[2:0]};
        check_stb  = 1'b1;
        @(posedge clk);
        #1 check_stb = 1'b0;
    endtask

    task automatic run_txn(input int tid, input int sid, input logic rw,
                           input logic [7:0] cmd_byte, input logic [15:0] value,
                           input logic addr_ack, input logic second_start);
        expect_t     e;
        logic [31:0] s;
        reading     = value;
        addr_ack_en = addr_ack;
        @(posedge clk);
        #1 model_clear = 1'b1;
        @(posedge clk);
        #1 model_clear = 1'b0;
        e = ref_expect(rw, cmd_byte, value, addr_ack, last_rdata);
        wb_write(REG_CTRL, {23'h000000, rw, cmd_byte});
        if (second_start) begin
            wb_read(REG_STATUS, s);
            if (!s[STATUS_BUSY]) begin
                $display("ERROR: DUT not busy when the second start was written");
                proto_errors++;
            end
            wb_write(REG_CTRL, {23'h000000, !rw, ~cmd_byte});   // must be dropped
        end
        wait_idle();
        submit(tid, sid, e.cap, e.rdata, {2'b00, 1'b1, e.nack, 1'b0},
               (rw && addr_ack) ? 2'b10 : 2'b00, 8'h11);
        last_rdata = e.rdata;
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("ERROR: watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] v;
        wb_req       = '0;
        model_clear  = 1'b0;
        addr_ack_en  = 1'b1;
        reading      = 16'h0000;
        check_stb    = 1'b0;
        report_stb   = 1'b0;
        test_id      = 0;
        sub_id       = 0;
        exp_cap      = '0;
        exp_rdata    = '0;
        obs_rdata    = '0;
        exp_status   = '0;
        obs_status   = '0;
        exp_mack     = '0;
        exp_frames   = '0;
        proto_errors = 0;
        last_rdata   = 16'h0000;
        r            = $urandom(32'h0960_3eae);
        @(posedge rst_n);

        submit(1, 0, 9'h000, 16'h0000, 5'h00, 2'b00, 8'h00);   // reset state
        run_txn(2, 0, 1'b0, 8'hD0, 16'h0000, 1'b1, 1'b0);
        run_txn(3, 0, 1'b1, 8'h00, 16'hA5C3, 1'b1, 1'b0);
        run_txn(4, 0, 1'b0, 8'h90, 16'h1234, 1'b0, 1'b0);
        run_txn(5, 0, 1'b1, 8'h00, 16'h3C7E, 1'b1, 1'b1);
        for (int i = 0; i < 20; i++) begin
            r = $urandom;
            v = $urandom;
            run_txn(6, i, r[8], r[7:0], v[15:0], 1'b1, 1'b0);
        end

        @(posedge clk);
        #1 report_stb = 1'b1;
        @(posedge clk);
        #1 report_stb = 1'b0;
        if (proto_errors != 0) begin
            $display("protocol errors: %0d", proto_errors);
        end
        if (fail_count == 0 && proto_errors == 0 && test_count == NUM_TESTS) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/i2c_bus_pkg.sv
hw/touch_regs_pkg.sv
hw/scl_tick_gen.sv
hw/i2c_byte_shifter.sv
hw/i2c_sequencer.sv
hw/touch_wb_regs.sv
hw/touch_i2c_top.sv
testbench/tb_clk_gen.sv
testbench/ns2009_model.sv
testbench/tb_checker.sv
testbench/tb_touch_i2c.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the touch I2C master testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_touch_i2c -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep "^Test OK$" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
